//--- include/ahb_matrix_params.svh
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// ============================================================
// Bus widths
// ============================================================

// Full AHB address word
`define AHB_ADDR_WIDTH 32

// Decoded slaves behind the matrix
`define AHB_SLAVE_NUM 2

// ============================================================
// Page split of the address word
// ============================================================

// Lowest bit of the page number, 1 KB pages
`define AHB_PAGE_LSB 10

// Page number width above the offset
`define AHB_PAGE_WIDTH (`AHB_ADDR_WIDTH - `AHB_PAGE_LSB)

// ============================================================
// Address map, inclusive page ranges
// ============================================================

// Slave 0, pages 8..9
`define AHB_S0_LOW_PAGE 8
`define AHB_S0_HIGH_PAGE 9

// Slave 1, pages 10..12
`define AHB_S1_LOW_PAGE 10
`define AHB_S1_HIGH_PAGE 12

`endif

//--- hw/ahb_pkg.sv
`include "ahb_matrix_params.svh"

package ahb_pkg;

  // ============================================================
  // Protocol encodings
  // ============================================================

  // AHB transfer type on htrans
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Single bit response, no split or retry
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // ============================================================
  // Address views
  // ============================================================

  // Page number over byte offset
  typedef struct packed {
    logic [`AHB_PAGE_WIDTH-1:0] page;
    logic [`AHB_PAGE_LSB-1:0]   offset;
  } ahb_page_addr_t;

  // Same word, seen raw or split into page and offset
  typedef union packed {
    logic [`AHB_ADDR_WIDTH-1:0] raw;
    ahb_page_addr_t             fields;
  } ahb_addr_u;

  // ============================================================
  // Per-master bundles
  // ============================================================

  // Address phase of one master, 34 bits
  typedef struct packed {
    ahb_addr_u addr;
    htrans_e   htrans;
  } ahb_req_t;

  // Decoder result, one request bit per slave
  typedef struct packed {
    logic [`AHB_SLAVE_NUM-1:0] hreq;
    logic                      default_sel;
  } ahb_dec_t;

  // Default slave response back to its master
  typedef struct packed {
    logic   hready;
    hresp_e hresp;
  } ahb_rsp_t;

endpackage

//--- hw/ahb_addr_decoder.sv
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_addr_decoder (
  input  ahb_pkg::ahb_req_t req,
  output ahb_pkg::ahb_dec_t dec
);

  // Page field width of the address union
  localparam int page_w = `AHB_PAGE_WIDTH;

  // ============================================================
  // Address map
  // ============================================================

  // Inclusive lower page bound per slave, slave 0 in the low entry
  localparam logic [`AHB_SLAVE_NUM-1:0][page_w-1:0] low_page = {
    page_w'(`AHB_S1_LOW_PAGE),
    page_w'(`AHB_S0_LOW_PAGE)
  };

  // Inclusive upper page bound per slave
  localparam logic [`AHB_SLAVE_NUM-1:0][page_w-1:0] high_page = {
    page_w'(`AHB_S1_HIGH_PAGE),
    page_w'(`AHB_S0_HIGH_PAGE)
  };

  // Page of the current address phase
  logic [page_w-1:0] page;

  // Region hit per slave before the htrans qualifier
  logic [`AHB_SLAVE_NUM-1:0] slave_hit;

  // Anything other than IDLE counts as a transfer
  logic active;

  // ============================================================
  // Region compare
  // ============================================================

  // Offset bits play no part in slave selection
  assign page = req.addr.fields.page;

  // BUSY still holds the address and stays active
  assign active = (req.htrans != ahb_pkg::IDLE);

  genvar i;
  generate
    for (i = 0; i < `AHB_SLAVE_NUM; i++) begin : g_region
      // Both ends of the range belong to the slave
      assign slave_hit[i] = (page >= low_page[i]) && (page <= high_page[i]);
    end
  endgenerate

  // ============================================================
  // Decode result
  // ============================================================

  always_comb begin
    // IDLE requests nothing
    dec.hreq        = '0;
    dec.default_sel = 1'b0;
    if (active) begin
      dec.hreq = slave_hit;
      // Miss on every window goes to the default slave
      dec.default_sel = ~|slave_hit;
    end
  end

endmodule

//--- hw/ahb_slave_arbiter.sv
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_slave_arbiter (
  input  logic                      hclk,
  input  logic                      rst,
  input  logic [`AHB_SLAVE_NUM-1:0] hreq_m0,
  input  logic [`AHB_SLAVE_NUM-1:0] hreq_m1,
  output logic [`AHB_SLAVE_NUM-1:0] hsel,
  output logic [`AHB_SLAVE_NUM-1:0] hmaster
);

  // ============================================================
  // Per-slave state
  // ============================================================

  // Slave currently granted to some master
  logic [`AHB_SLAVE_NUM-1:0] granted_q;
  logic [`AHB_SLAVE_NUM-1:0] granted_d;

  // Owning master, 0 or 1
  logic [`AHB_SLAVE_NUM-1:0] owner_q;
  logic [`AHB_SLAVE_NUM-1:0] owner_d;

  // Master that wins a tie on a free slave
  logic [`AHB_SLAVE_NUM-1:0] prio_q;
  logic [`AHB_SLAVE_NUM-1:0] prio_d;

  // ============================================================
  // Hold and rotate
  // ============================================================

  always_comb begin
    logic [1:0] req;
    logic       hold;
    logic       pick;

    granted_d = granted_q;
    owner_d   = owner_q;
    prio_d    = prio_q;
    req       = '0;
    hold      = 1'b0;
    pick      = 1'b0;

    for (int s = 0; s < `AHB_SLAVE_NUM; s++) begin
      // Bit k is the request from master k
      req = {hreq_m1[s], hreq_m0[s]};

      // Owner still asking keeps the slave
      hold = granted_q[s] & req[owner_q[s]];

      // On release the other master goes first
      pick = granted_q[s] ? ~owner_q[s] : prio_q[s];

      if (!hold) begin
        granted_d[s] = |req;
        if (req[pick]) begin
          owner_d[s] = pick;
        end else if (req[~pick]) begin
          owner_d[s] = ~pick;
        end
        // Priority only moves when an owner lets go
        if (granted_q[s]) begin
          prio_d[s] = ~owner_q[s];
        end
      end
    end
  end

  // ============================================================
  // State registers
  // ============================================================

  always_ff @(posedge hclk) begin
    if (rst) begin
      // Nothing granted, master 0 first everywhere
      granted_q <= '0;
      owner_q   <= '0;
      prio_q    <= '0;
    end else begin
      granted_q <= granted_d;
      owner_q   <= owner_d;
      prio_q    <= prio_d;
    end
  end

  // Registered grant outputs
  assign hsel = granted_q;

  // Last owner stays visible while the slave is free
  assign hmaster = owner_q;

endmodule

//--- hw/ahb_default_slave.sv
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic              hclk,
  input  logic              rst,
  input  logic              default_sel,
  output ahb_pkg::ahb_rsp_t rsp
);

  // ============================================================
  // ERROR sequencer
  // ============================================================

  // First cycle of the response, wait state
  logic err_wait_q;

  // Second cycle, transfer completes with ERROR
  logic err_done_q;

  // Response in flight
  logic busy;

  assign busy = err_wait_q | err_done_q;

  always_ff @(posedge hclk) begin
    if (rst) begin
      err_wait_q <= 1'b0;
      err_done_q <= 1'b0;
    end else begin
      // Select while busy is dropped, master is still stalled
      err_wait_q <= default_sel & ~busy;
      // Wait cycle always leads into the completion cycle
      err_done_q <= err_wait_q;
    end
  end

  // ============================================================
  // Response outputs
  // ============================================================

  // hready low only in the wait cycle
  assign rsp.hready = ~err_wait_q;

  // ERROR held over both cycles, OKAY otherwise
  assign rsp.hresp = busy ? ahb_pkg::ERROR : ahb_pkg::OKAY;

endmodule

//--- hw/ahb_matrix_top.sv
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_matrix_top (
  input  logic                      hclk,
  input  logic                      rst,
  input  ahb_pkg::ahb_req_t         m0_req,
  input  ahb_pkg::ahb_req_t         m1_req,
  output logic [`AHB_SLAVE_NUM-1:0] hsel,
  output logic [`AHB_SLAVE_NUM-1:0] hmaster,
  output ahb_pkg::ahb_rsp_t         m0_rsp,
  output ahb_pkg::ahb_rsp_t         m1_rsp
);

  // Decoder results, one per master
  ahb_pkg::ahb_dec_t dec_0;
  ahb_pkg::ahb_dec_t dec_1;

  // ============================================================
  // Address decode, masters side by side
  // ============================================================

  // Master 0 decoder
  ahb_addr_decoder u_dec_m0 (
    .req (m0_req),
    .dec (dec_0)
  );

  // Master 1 decoder
  ahb_addr_decoder u_dec_m1 (
    .req (m1_req),
    .dec (dec_1)
  );

  // ============================================================
  // Slave arbitration
  // ============================================================

  // Grants registered, one edge after the request
  ahb_slave_arbiter u_arb (
    .hclk    (hclk),
    .rst     (rst),
    .hreq_m0 (dec_0.hreq),
    .hreq_m1 (dec_1.hreq),
    .hsel    (hsel),
    .hmaster (hmaster)
  );

  // ============================================================
  // Default slaves
  // ============================================================

  // Unmapped accesses from master 0
  ahb_default_slave u_dflt_m0 (
    .hclk        (hclk),
    .rst         (rst),
    .default_sel (dec_0.default_sel),
    .rsp         (m0_rsp)
  );

  // Unmapped accesses from master 1
  ahb_default_slave u_dflt_m1 (
    .hclk        (hclk),
    .rst         (rst),
    .default_sel (dec_1.default_sel),
    .rsp         (m1_rsp)
  );

endmodule

//--- sim/ahb_matrix_asserts.sv
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_matrix_asserts (
  input logic                      hclk,
  input logic                      rst,
  input ahb_pkg::ahb_dec_t         dec_0,
  input ahb_pkg::ahb_dec_t         dec_1,
  input logic [`AHB_SLAVE_NUM-1:0] hsel,
  input logic [`AHB_SLAVE_NUM-1:0] hmaster,
  input ahb_pkg::ahb_rsp_t         m0_rsp,
  input ahb_pkg::ahb_rsp_t         m1_rsp
);

  // Failed assertions so far
  int assert_fails = 0;

  // Request of the current owner of each slave
  logic [`AHB_SLAVE_NUM-1:0] owner_req;

  // ============================================================
  // Grants
  // ============================================================

  // Nothing granted right out of reset
  a_hsel_after_reset: assert property (@(posedge hclk) $past(rst) && !rst |-> hsel == '0)
    else begin
      assert_fails++;
      $error("hsel set in the first cycle after reset");
    end

  genvar s;
  generate
    for (s = 0; s < `AHB_SLAVE_NUM; s++) begin : g_hold
      assign owner_req[s] = hmaster[s] ? dec_1.hreq[s] : dec_0.hreq[s];

      // Owner still asking keeps the same grant
      a_grant_hold: assert property (@(posedge hclk) disable iff (rst)
        hsel[s] && owner_req[s] |=> hsel[s] && (hmaster[s] == $past(hmaster[s])))
        else begin
          assert_fails++;
          $error("grant moved while its owner kept requesting");
        end
    end
  endgenerate

  // ============================================================
  // Default slave responses
  // ============================================================

  // Wait cycle leads to the ERROR completion
  a_m0_err_pair: assert property (@(posedge hclk) disable iff (rst)
    !m0_rsp.hready |=> (m0_rsp.hresp == ahb_pkg::ERROR))
    else begin
      assert_fails++;
      $error("master 0 wait state not followed by ERROR");
    end

  a_m1_err_pair: assert property (@(posedge hclk) disable iff (rst)
    !m1_rsp.hready |=> (m1_rsp.hresp == ahb_pkg::ERROR))
    else begin
      assert_fails++;
      $error("master 1 wait state not followed by ERROR");
    end

  // Only a single wait state
  a_m0_one_wait: assert property (@(posedge hclk) disable iff (rst)
    !m0_rsp.hready |=> m0_rsp.hready)
    else begin
      assert_fails++;
      $error("master 0 hready low two cycles in a row");
    end

  a_m1_one_wait: assert property (@(posedge hclk) disable iff (rst)
    !m1_rsp.hready |=> m1_rsp.hready)
    else begin
      assert_fails++;
      $error("master 1 hready low two cycles in a row");
    end

endmodule

bind ahb_matrix_top ahb_matrix_asserts u_asserts (
  .hclk    (hclk),
  .rst     (rst),
  .dec_0   (dec_0),
  .dec_1   (dec_1),
  .hsel    (hsel),
  .hmaster (hmaster),
  .m0_rsp  (m0_rsp),
  .m1_rsp  (m1_rsp)
);

//--- sim/ahb_matrix_tb.sv
`timescale 1ns/1ps
`include "ahb_matrix_params.svh"

module ahb_matrix_tb;

  // ============================================================
  // Run length and timeout
  // ============================================================

  localparam int page_w        = `AHB_ADDR_WIDTH - `AHB_PAGE_LSB;
  localparam int reset_cycles  = 16;
  localparam int decode_cycles = 400;
  localparam int err_rounds    = 8;
  localparam int err_len       = 7;
  localparam int cont_rounds   = 6;
  localparam int cont_len      = 10;
  localparam int random_cycles = 3000;
  localparam int cycle_limit   = reset_cycles + 1 + decode_cycles + err_rounds * err_len
                                 + cont_rounds * cont_len + random_cycles + 200;

  logic                      hclk;
  logic                      rst;
  ahb_pkg::ahb_req_t         m0_req;
  ahb_pkg::ahb_req_t         m1_req;
  logic [`AHB_SLAVE_NUM-1:0] hsel;
  logic [`AHB_SLAVE_NUM-1:0] hmaster;
  ahb_pkg::ahb_rsp_t         m0_rsp;
  ahb_pkg::ahb_rsp_t         m1_rsp;

  // Reference model state
  logic [`AHB_SLAVE_NUM-1:0] m_granted;
  logic [`AHB_SLAVE_NUM-1:0] m_owner;
  logic [`AHB_SLAVE_NUM-1:0] m_prio;
  logic [1:0]                m_wait;
  logic [1:0]                m_done;

  logic [31:0] rng_state;
  int          cycle_count;
  int          error_count;
  int          check_count;
  int          tests_run;
  int          tests_failed;
  int          total_errors;

  ahb_matrix_top dut0 (
    .hclk    (hclk),
    .rst     (rst),
    .m0_req  (m0_req),
    .m1_req  (m1_req),
    .hsel    (hsel),
    .hmaster (hmaster),
    .m0_rsp  (m0_rsp),
    .m1_rsp  (m1_rsp)
  );

  // 4 ns clock
  initial hclk = 1'b0;
  always #2 hclk = ~hclk;

  always @(posedge hclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ============================================================
  // Random numbers and stimulus
  // ============================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic ahb_pkg::ahb_req_t make_req(input logic [page_w-1:0] page,
                                                 input logic [`AHB_PAGE_LSB-1:0] offset,
                                                 input ahb_pkg::htrans_e htrans);
    ahb_pkg::ahb_req_t rq;
    rq.addr.raw = {page, offset};
    rq.htrans   = htrans;
    return rq;
  endfunction

  function automatic ahb_pkg::ahb_req_t idle_req();
    ahb_pkg::ahb_req_t rq;
    rq = '0;
    return rq;
  endfunction

  // Mostly mapped pages, some region edges, some far away
  function automatic ahb_pkg::ahb_req_t random_req();
    logic [31:0]       r;
    logic [31:0]       r2;
    logic [page_w-1:0] page;
    r  = next_rand();
    r2 = next_rand();
    if (r[2:0] < 3'd5) begin
      page = page_w'(`AHB_S0_LOW_PAGE + r[7:3] % 5);
    end else if (r[2:0] == 3'd5) begin
      page = r[8] ? page_w'(`AHB_S0_LOW_PAGE - 1) : page_w'(`AHB_S1_HIGH_PAGE + 1);
    end else begin
      page = r2[31:`AHB_PAGE_LSB];
    end
    return make_req(page, r[31:22], ahb_pkg::htrans_e'(r[12:11]));
  endfunction

  // Active access that hits no slave window
  function automatic ahb_pkg::ahb_req_t unmapped_req();
    logic [31:0]       r;
    logic [page_w-1:0] page;
    r = next_rand();
    case (r[1:0])
      2'd0: page = page_w'(`AHB_S0_LOW_PAGE - 1);
      2'd1: page = page_w'(`AHB_S1_HIGH_PAGE + 1);
      default: page = {1'b1, r[page_w-2:0]};
    endcase
    return make_req(page, r[31:22], r[2] ? ahb_pkg::NONSEQ : ahb_pkg::SEQ);
  endfunction

  // ============================================================
  // Reference model
  // ============================================================

  // Bits 2..1 slave requests, bit 0 default select
  function automatic logic [2:0] map_page(input ahb_pkg::ahb_req_t r);
    logic [page_w-1:0] page;
    logic              in_s0;
    logic              in_s1;
    page  = r.addr.raw[`AHB_ADDR_WIDTH-1:`AHB_PAGE_LSB];
    in_s0 = page >= page_w'(`AHB_S0_LOW_PAGE) && page <= page_w'(`AHB_S0_HIGH_PAGE);
    in_s1 = page >= page_w'(`AHB_S1_LOW_PAGE) && page <= page_w'(`AHB_S1_HIGH_PAGE);
    if (r.htrans == ahb_pkg::IDLE) begin
      return 3'b000;
    end
    return {in_s1, in_s0, ~(in_s0 | in_s1)};
  endfunction

  task automatic model_reset();
    m_granted = '0;
    m_owner   = '0;
    m_prio    = '0;
    m_wait    = '0;
    m_done    = '0;
  endtask

  task automatic model_advance(input logic [2:0] d0, input logic [2:0] d1);
    logic r0;
    logic r1;
    logic own_req;
    logic other_req;
    logic sel;
    logic busy;
    for (int s = 0; s < `AHB_SLAVE_NUM; s++) begin
      r0        = d0[s+1];
      r1        = d1[s+1];
      own_req   = m_owner[s] ? r1 : r0;
      other_req = m_owner[s] ? r0 : r1;
      if (m_granted[s] && own_req) begin
        // Owner keeps the slave, nothing moves
      end else if (m_granted[s]) begin
        // Release hands priority to the other master
        m_prio[s]    = ~m_owner[s];
        m_granted[s] = other_req;
        if (other_req) m_owner[s] = ~m_owner[s];
      end else begin
        m_granted[s] = r0 | r1;
        if (r0 && r1) m_owner[s] = m_prio[s];
        else if (r0) m_owner[s] = 1'b0;
        else if (r1) m_owner[s] = 1'b1;
      end
    end
    for (int m = 0; m < 2; m++) begin
      sel       = m ? d1[0] : d0[0];
      busy      = m_wait[m] | m_done[m];
      m_done[m] = m_wait[m];
      m_wait[m] = sel & ~busy;
    end
  endtask

  // ============================================================
  // Checking
  // ============================================================

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  function automatic logic [1:0] rsp_of(input int m);
    return m ? {m1_rsp.hready, m1_rsp.hresp} : {m0_rsp.hready, m0_rsp.hresp};
  endfunction

  task automatic check_outputs();
    logic [1:0] exp_rsp;
    check(32'(hsel), 32'(m_granted), "hsel");
    for (int s = 0; s < `AHB_SLAVE_NUM; s++) begin
      if (m_granted[s]) check(32'(hmaster[s]), 32'(m_owner[s]), $sformatf("hmaster[%0d]", s));
    end
    for (int m = 0; m < 2; m++) begin
      // hready low only while waiting, ERROR over both cycles
      exp_rsp = {~m_wait[m], m_wait[m] | m_done[m]};
      check(32'(rsp_of(m)), 32'(exp_rsp), $sformatf("m%0d response", m));
    end
  endtask

  // Drive on the rising edge, compare at the falling edge
  task automatic run_cycle(input ahb_pkg::ahb_req_t r0, input ahb_pkg::ahb_req_t r1);
    @(posedge hclk);
    m0_req <= r0;
    m1_req <= r1;
    @(negedge hclk);
    check_outputs();
    model_advance(map_page(r0), map_page(r1));
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count > errs_before) tests_failed++;
    $display("test %s done, %0d mismatches", name, error_count - errs_before);
  endtask

  // ============================================================
  // Tests
  // ============================================================

  task automatic test_reset();
    int errs_before;
    errs_before = error_count;
    @(negedge hclk);
    check(32'(hsel), 32'd0, "hsel after reset");
    check(32'(rsp_of(0)), 32'h2, "m0 response after reset");
    check(32'(rsp_of(1)), 32'h2, "m1 response after reset");
    finish_test("reset", errs_before);
  endtask

  task automatic test_decode();
    int                        errs_before;
    logic [31:0]               r;
    logic [2:0]                d;
    logic [`AHB_SLAVE_NUM-1:0] prev_hreq;
    ahb_pkg::ahb_req_t         q;
    errs_before = error_count;
    prev_hreq   = '0;
    for (int i = 0; i < decode_cycles; i++) begin
      r = next_rand();
      q = random_req();
      if (r[0]) run_cycle(idle_req(), q);
      else run_cycle(q, idle_req());
      // One master at a time, grant mirrors last cycle's map
      check(32'(hsel), 32'(prev_hreq), "decoded hsel");
      d         = map_page(q);
      prev_hreq = d[2:1];
    end
    finish_test("decode", errs_before);
  endtask

  task automatic test_errors();
    int                errs_before;
    int                m;
    ahb_pkg::ahb_req_t bad;
    errs_before = error_count;
    for (int rnd = 0; rnd < err_rounds; rnd++) begin
      m = rnd % 2;
      // Let any earlier response drain
      repeat (3) run_cycle(idle_req(), idle_req());
      for (int k = 0; k < 4; k++) begin
        bad = (k < 3) ? unmapped_req() : idle_req();
        if (m) run_cycle(idle_req(), bad);
        else run_cycle(bad, idle_req());
        if (k == 1) begin
          check(32'(rsp_of(m)), 32'h1, "error wait cycle");
          check(32'(rsp_of(1 - m)), 32'h2, "other master response");
        end
        if (k == 2) check(32'(rsp_of(m)), 32'h3, "error completion cycle");
        // Selects during the response were dropped
        if (k == 3) check(32'(rsp_of(m)), 32'h2, "response after error pair");
      end
    end
    finish_test("errors", errs_before);
  endtask

  task automatic test_contention();
    int                errs_before;
    int                s;
    logic              winner;
    logic              loser;
    logic [31:0]       r;
    ahb_pkg::ahb_req_t q0;
    ahb_pkg::ahb_req_t q1;
    errs_before = error_count;
    for (int rnd = 0; rnd < cont_rounds; rnd++) begin
      s  = rnd % 2;
      r  = next_rand();
      q0 = make_req((s == 0) ? page_w'(8) : page_w'(11), r[9:0], ahb_pkg::NONSEQ);
      q1 = make_req((s == 0) ? page_w'(9) : page_w'(12), r[19:10], ahb_pkg::SEQ);
      repeat (2) run_cycle(idle_req(), idle_req());
      // Free slave, tie goes to the priority holder
      winner = m_prio[s];
      loser  = ~winner;
      for (int k = 0; k < 5; k++) begin
        run_cycle(q0, q1);
        if (k > 0) begin
          check(32'(hsel[s]), 32'd1, "contended hsel");
          check(32'(hmaster[s]), 32'(winner), "held owner");
        end
      end
      // Winner drops, the waiting master takes over
      for (int k = 0; k < 3; k++) begin
        if (winner) run_cycle(q0, idle_req());
        else run_cycle(idle_req(), q1);
        if (k > 0) begin
          check(32'(hsel[s]), 32'd1, "rotated hsel");
          check(32'(hmaster[s]), 32'(loser), "rotated owner");
        end
      end
    end
    finish_test("contention", errs_before);
  endtask

  task automatic test_random();
    int                errs_before;
    logic [31:0]       r;
    ahb_pkg::ahb_req_t cur0;
    ahb_pkg::ahb_req_t cur1;
    errs_before = error_count;
    cur0        = idle_req();
    cur1        = idle_req();
    for (int i = 0; i < random_cycles; i++) begin
      r = next_rand();
      // Requests tend to persist so holds and waits happen
      if (r[2:0] < 3'd3) cur0 = random_req();
      if (r[5:3] < 3'd3) cur1 = random_req();
      run_cycle(cur0, cur1);
    end
    finish_test("random", errs_before);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================

  initial begin
    rst          = 1'b1;
    m0_req       = '0;
    m1_req       = '0;
    rng_state    = 32'd39;
    cycle_count  = 0;
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_reset();
    repeat (reset_cycles) @(posedge hclk);
    rst <= 1'b0;
    test_reset();
    test_decode();
    test_errors();
    test_contention();
    test_random();
    total_errors = error_count + dut0.u_asserts.assert_fails;
    $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion fails",
             tests_run, tests_failed, check_count, error_count, dut0.u_asserts.assert_fails);
    if (total_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
hw/ahb_pkg.sv
hw/ahb_addr_decoder.sv
hw/ahb_slave_arbiter.sv
hw/ahb_default_slave.sv
hw/ahb_matrix_top.sv
sim/ahb_matrix_asserts.sv
sim/ahb_matrix_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ahb_matrix_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
